// File: hdl/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    localparam int xlen = 32;

    // instruction kind seen by the memory slice
    typedef enum logic [3:0] {
        op_alu,
        op_ld_b,
        op_ld_bu,
        op_ld_h,
        op_ld_hu,
        op_ld_w,
        op_st_b,
        op_st_h,
        op_st_w
    } mem_op_t;

    typedef logic [4:0] reg_addr_t;

    typedef logic [xlen-1:0] pc_t;

endpackage

`default_nettype wire

// File: hdl/dmem_pkg.sv
`default_nettype none

package dmem_pkg;

    localparam int dmem_words  = 256;
    localparam int dmem_addr_w = $clog2(dmem_words);
    localparam int dmem_lanes  = 4;

    // word index into the data SRAM
    typedef logic [dmem_addr_w-1:0] dmem_addr_t;

    typedef logic [dmem_lanes-1:0] byte_en_t;

endpackage

`default_nettype wire

// File: hdl/ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      flush,
    input  logic                      in_valid,
    input  pipe_pkg::pc_t             in_pc,
    input  pipe_pkg::mem_op_t         in_op,
    input  pipe_pkg::reg_addr_t       in_dest,
    input  logic [pipe_pkg::xlen-1:0] in_base,
    input  logic [pipe_pkg::xlen-1:0] in_offset,
    input  logic [pipe_pkg::xlen-1:0] in_data,
    output logic                      in_allowin,
    input  logic                      ms_allowin,
    output logic                      es_to_ms_valid,
    output pipe_pkg::pc_t             es_pc,
    output pipe_pkg::mem_op_t         es_op,
    output pipe_pkg::reg_addr_t       es_dest,
    output logic [pipe_pkg::xlen-1:0] es_addr,
    output logic [pipe_pkg::xlen-1:0] es_data,
    output logic                      es_excp,
    output logic                      sram_en,
    output dmem_pkg::byte_en_t        sram_be,
    output dmem_pkg::dmem_addr_t      sram_addr,
    output logic [pipe_pkg::xlen-1:0] sram_wdata
);
    import pipe_pkg::*;
    import dmem_pkg::*;

    logic            es_valid;
    logic            es_ready_go;
    logic            es_go;
    logic [xlen-1:0] es_base;
    logic [xlen-1:0] es_offset;
    logic            is_load;
    logic            is_store;
    logic            is_half;
    logic            is_word;

    assign es_ready_go    = !flush;
    assign in_allowin     = !es_valid || es_ready_go && ms_allowin || flush;
    assign es_to_ms_valid = es_valid && es_ready_go;
    assign es_go          = es_to_ms_valid && ms_allowin;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            es_valid <= 1'b0;
        end else if (in_allowin) begin
            es_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            es_pc     <= in_pc;
            es_op     <= in_op;
            es_dest   <= in_dest;
            es_base   <= in_base;
            es_offset <= in_offset;
            es_data   <= in_data;
        end
    end

    assign is_load  = es_op inside {op_ld_b, op_ld_bu, op_ld_h, op_ld_hu, op_ld_w};
    assign is_store = es_op inside {op_st_b, op_st_h, op_st_w};
    assign is_half  = es_op inside {op_ld_h, op_ld_hu, op_st_h};
    assign is_word  = es_op inside {op_ld_w, op_st_w};

    assign es_addr = es_base + es_offset;
    assign es_excp = is_half && es_addr[0] || is_word && (es_addr[1:0] != 2'b00);

    // one access per item on the move into mem
    assign sram_en   = es_go && (is_load || is_store) && !es_excp;
    assign sram_addr = es_addr[dmem_addr_w+1:2];

    always_comb begin
        sram_be    = '0;
        sram_wdata = es_data;
        case (es_op)
            op_st_b: begin
                sram_be    = 4'b0001 << es_addr[1:0];
                sram_wdata = {4{es_data[7:0]}};
            end
            op_st_h: begin
                sram_be    = es_addr[1] ? 4'b1100 : 4'b0011;
                sram_wdata = {2{es_data[15:0]}};
            end
            op_st_w: begin
                sram_be = 4'b1111;
            end
            default: begin
                sram_be = '0;
            end
        endcase
        if (!sram_en) begin
            sram_be = '0;
        end
    end

endmodule

`default_nettype wire

// File: hdl/data_sram.sv
`timescale 1ns/1ps
`default_nettype none

module data_sram (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      en,
    input  dmem_pkg::byte_en_t        be,
    input  dmem_pkg::dmem_addr_t      addr,
    input  logic [pipe_pkg::xlen-1:0] wdata,
    output logic [pipe_pkg::xlen-1:0] rdata,
    output logic                      rdata_valid
);
    import pipe_pkg::*;
    import dmem_pkg::*;

    logic [xlen-1:0] mem [dmem_words];
    logic [xlen-1:0] rdata_q;

    // a zero byte mask means read
    always_ff @(posedge clk) begin
        if (en) begin
            for (int i = 0; i < dmem_lanes; i++) begin
                if (be[i]) begin
                    mem[addr][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
            if (be == '0) begin
                rdata_q <= mem[addr];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rdata_valid <= 1'b0;
        end else begin
            rdata_valid <= en && (be == '0);
        end
    end

    assign rdata = rdata_valid ? rdata_q : '0;

endmodule

`default_nettype wire

// File: hdl/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      flush,
    input  logic                      es_to_ms_valid,
    input  pipe_pkg::pc_t             es_pc,
    input  pipe_pkg::mem_op_t         es_op,
    input  pipe_pkg::reg_addr_t       es_dest,
    input  logic [pipe_pkg::xlen-1:0] es_addr,
    input  logic [pipe_pkg::xlen-1:0] es_data,
    input  logic                      es_excp,
    output logic                      ms_allowin,
    input  logic [pipe_pkg::xlen-1:0] rdata,
    input  logic                      rdata_valid,
    input  logic                      ws_allowin,
    output logic                      ms_to_ws_valid,
    output pipe_pkg::pc_t             ms_pc,
    output pipe_pkg::reg_addr_t       ms_dest,
    output logic                      ms_we,
    output logic [pipe_pkg::xlen-1:0] ms_result,
    output logic                      ms_excp
);
    import pipe_pkg::*;

    logic            ms_valid;
    logic            ms_ready_go;
    mem_op_t         op_r;
    logic [xlen-1:0] addr_r;
    logic [xlen-1:0] data_r;
    logic            excp_r;
    logic [xlen-1:0] rdata_buf;
    logic            rdata_buf_valid;
    logic [xlen-1:0] final_rdata;
    logic [7:0]      ld_byte;
    logic [15:0]     ld_half;
    logic [xlen-1:0] ld_result;
    logic            is_load;

    assign ms_ready_go    = !flush;
    assign ms_allowin     = !ms_valid || ms_ready_go && ws_allowin || flush;
    assign ms_to_ws_valid = ms_valid && ms_ready_go;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es_to_ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_to_ms_valid && ms_allowin) begin
            ms_pc   <= es_pc;
            op_r    <= es_op;
            ms_dest <= es_dest;
            addr_r  <= es_addr;
            data_r  <= es_data;
            excp_r  <= es_excp;
        end
    end

    // keep returned data while wb refuses the item
    always_ff @(posedge clk) begin
        if (rdata_valid && !ws_allowin) begin
            rdata_buf <= rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            rdata_buf_valid <= 1'b0;
        end else if (rdata_valid && !ws_allowin) begin
            rdata_buf_valid <= 1'b1;
        end else if (ms_to_ws_valid && ws_allowin) begin
            rdata_buf_valid <= 1'b0;
        end
    end

    assign final_rdata = rdata_buf_valid ? rdata_buf : rdata;

    // lane select by low address bits
    assign ld_byte = final_rdata[8*addr_r[1:0] +: 8];
    assign ld_half = final_rdata[16*addr_r[1] +: 16];

    always_comb begin
        case (op_r)
            op_ld_b:  ld_result = {{24{ld_byte[7]}}, ld_byte};
            op_ld_bu: ld_result = {24'b0, ld_byte};
            op_ld_h:  ld_result = {{16{ld_half[15]}}, ld_half};
            op_ld_hu: ld_result = {16'b0, ld_half};
            default:  ld_result = final_rdata;
        endcase
    end

    assign is_load = op_r inside {op_ld_b, op_ld_bu, op_ld_h, op_ld_hu, op_ld_w};

    // faulting access reports its address
    always_comb begin
        if (excp_r) begin
            ms_result = addr_r;
        end else if (is_load) begin
            ms_result = ld_result;
        end else begin
            ms_result = data_r;
        end
    end

    assign ms_we   = !excp_r && (is_load || op_r == op_alu);
    assign ms_excp = excp_r;

endmodule

`default_nettype wire

// File: hdl/wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module wb_stage (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      flush,
    input  logic                      ms_to_ws_valid,
    input  pipe_pkg::pc_t             ms_pc,
    input  pipe_pkg::reg_addr_t       ms_dest,
    input  logic                      ms_we,
    input  logic [pipe_pkg::xlen-1:0] ms_result,
    input  logic                      ms_excp,
    output logic                      ws_allowin,
    input  logic                      retire_stall,
    output logic                      wb_valid,
    output pipe_pkg::pc_t             wb_pc,
    output pipe_pkg::reg_addr_t       wb_dest,
    output logic                      wb_we,
    output logic [pipe_pkg::xlen-1:0] wb_data,
    output logic                      wb_excp
);
    import pipe_pkg::*;

    logic            ws_valid;
    logic            ws_ready_go;
    pc_t             ws_pc;
    reg_addr_t       ws_dest;
    logic            ws_we;
    logic [xlen-1:0] ws_data;
    logic            ws_excp;

    assign ws_ready_go = !retire_stall && !flush;
    assign ws_allowin  = !ws_valid || ws_ready_go || flush;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            ws_valid <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid <= ms_to_ws_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms_to_ws_valid && ws_allowin) begin
            ws_pc   <= ms_pc;
            ws_dest <= ms_dest;
            ws_we   <= ms_we;
            ws_data <= ms_result;
            ws_excp <= ms_excp;
        end
    end

    // an item caught by flush never shows as valid
    assign wb_valid = ws_valid && !flush;
    assign wb_pc    = ws_pc;
    assign wb_dest  = ws_dest;
    assign wb_we    = ws_we;
    assign wb_data  = ws_data;
    assign wb_excp  = ws_excp;

endmodule

`default_nettype wire

// File: hdl/mem_pipe_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_pipe_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      flush,
    input  logic                      in_valid,
    input  pipe_pkg::pc_t             in_pc,
    input  pipe_pkg::mem_op_t         in_op,
    input  pipe_pkg::reg_addr_t       in_dest,
    input  logic [pipe_pkg::xlen-1:0] in_base,
    input  logic [pipe_pkg::xlen-1:0] in_offset,
    input  logic [pipe_pkg::xlen-1:0] in_data,
    output logic                      in_allowin,
    input  logic                      retire_stall,
    output logic                      wb_valid,
    output pipe_pkg::pc_t             wb_pc,
    output pipe_pkg::reg_addr_t       wb_dest,
    output logic                      wb_we,
    output logic [pipe_pkg::xlen-1:0] wb_data,
    output logic                      wb_excp
);
    import pipe_pkg::*;
    import dmem_pkg::*;

    logic            ms_allowin;
    logic            ws_allowin;
    logic            es_to_ms_valid;
    pc_t             es_pc;
    mem_op_t         es_op;
    reg_addr_t       es_dest;
    logic [xlen-1:0] es_addr;
    logic [xlen-1:0] es_data;
    logic            es_excp;
    logic            sram_en;
    byte_en_t        sram_be;
    dmem_addr_t      sram_addr;
    logic [xlen-1:0] sram_wdata;
    logic [xlen-1:0] sram_rdata;
    logic            sram_rdata_valid;
    logic            ms_to_ws_valid;
    pc_t             ms_pc;
    reg_addr_t       ms_dest;
    logic            ms_we;
    logic [xlen-1:0] ms_result;
    logic            ms_excp;

    ex_stage i_ex_stage (
        .clk, .reset, .flush,
        .in_valid, .in_pc, .in_op, .in_dest, .in_base, .in_offset, .in_data,
        .in_allowin, .ms_allowin, .es_to_ms_valid,
        .es_pc, .es_op, .es_dest, .es_addr, .es_data, .es_excp,
        .sram_en, .sram_be, .sram_addr, .sram_wdata
    );

    data_sram i_data_sram (
        .clk, .reset,
        .en          (sram_en),
        .be          (sram_be),
        .addr        (sram_addr),
        .wdata       (sram_wdata),
        .rdata       (sram_rdata),
        .rdata_valid (sram_rdata_valid)
    );

    mem_stage i_mem_stage (
        .clk, .reset, .flush,
        .es_to_ms_valid, .es_pc, .es_op, .es_dest, .es_addr, .es_data, .es_excp,
        .ms_allowin,
        .rdata       (sram_rdata),
        .rdata_valid (sram_rdata_valid),
        .ws_allowin, .ms_to_ws_valid,
        .ms_pc, .ms_dest, .ms_we, .ms_result, .ms_excp
    );

    wb_stage i_wb_stage (
        .clk, .reset, .flush,
        .ms_to_ws_valid, .ms_pc, .ms_dest, .ms_we, .ms_result, .ms_excp,
        .ws_allowin, .retire_stall,
        .wb_valid, .wb_pc, .wb_dest, .wb_we, .wb_data, .wb_excp
    );

endmodule

`default_nettype wire

// File: testbench/tb_mem_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_pipe;
    import pipe_pkg::*;
    import dmem_pkg::*;

    typedef struct packed {
        mem_op_t         op;
        reg_addr_t       dest;
        logic [xlen-1:0] base;
        logic [xlen-1:0] offset;
        logic [xlen-1:0] data;
        logic            flush;
    } row_t;

    typedef struct packed {
        pc_t             pc;
        reg_addr_t       dest;
        mem_op_t         op;
        logic [xlen-1:0] data;
        logic            we;
        logic            excp;
    } exp_t;

    logic            clk;
    logic            reset;
    logic            flush;
    logic            in_valid;
    pc_t             in_pc;
    mem_op_t         in_op;
    reg_addr_t       in_dest;
    logic [xlen-1:0] in_base;
    logic [xlen-1:0] in_offset;
    logic [xlen-1:0] in_data;
    logic            in_allowin;
    logic            retire_stall;
    logic            wb_valid;
    pc_t             wb_pc;
    reg_addr_t       wb_dest;
    logic            wb_we;
    logic [xlen-1:0] wb_data;
    logic            wb_excp;

    row_t            rows [64];
    int              n_rows;
    logic [xlen-1:0] ref_mem [dmem_words];
    exp_t            exp_q [$];
    exp_t            retired;
    logic            stall_on;
    int              mismatches;
    int              failures;

    mem_pipe_top i_mem_pipe_top (
        .clk, .reset, .flush,
        .in_valid, .in_pc, .in_op, .in_dest, .in_base, .in_offset, .in_data,
        .in_allowin, .retire_stall,
        .wb_valid, .wb_pc, .wb_dest, .wb_we, .wb_data, .wb_excp
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        #1;
        retire_stall = stall_on && (($urandom % 3) == 0);
    end

    task automatic add_row(mem_op_t op, reg_addr_t dest, logic [xlen-1:0] base,
                           logic [xlen-1:0] offset, logic [xlen-1:0] data, logic fl);
        rows[n_rows] = '{op, dest, base, offset, data, fl};
        n_rows++;
    endtask

    function automatic logic misaligned(mem_op_t op, logic [xlen-1:0] addr);
        case (op)
            op_ld_h, op_ld_hu, op_st_h: return addr[0];
            op_ld_w, op_st_w: return addr[1:0] != 2'b00;
            default: return 1'b0;
        endcase
    endfunction

    // reference model that updates ref_mem for stores in program order
    function automatic exp_t predict_retirement(pc_t pc, row_t r);
        exp_t            e;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] word;
        logic [7:0]      b;
        logic [15:0]     h;
        addr   = r.base + r.offset;
        word   = ref_mem[addr[9:2]];
        b      = word[8*addr[1:0] +: 8];
        h      = word[16*addr[1] +: 16];
        e.pc   = pc;
        e.dest = r.dest;
        e.op   = r.op;
        e.data = r.data;
        e.we   = 1'b0;
        e.excp = 1'b0;
        if (misaligned(r.op, addr)) begin
            e.data = addr;
            e.excp = 1'b1;
        end else begin
            case (r.op)
                op_alu:   e.we = 1'b1;
                op_ld_b:  e.data = {{24{b[7]}}, b};
                op_ld_bu: e.data = {24'b0, b};
                op_ld_h:  e.data = {{16{h[15]}}, h};
                op_ld_hu: e.data = {16'b0, h};
                op_ld_w:  e.data = word;
                op_st_b:  ref_mem[addr[9:2]][8*addr[1:0] +: 8] = r.data[7:0];
                op_st_h:  ref_mem[addr[9:2]][16*addr[1] +: 16] = r.data[15:0];
                op_st_w:  ref_mem[addr[9:2]] = r.data;
                default:  e.we = 1'b0;
            endcase
            if (r.op inside {op_ld_b, op_ld_bu, op_ld_h, op_ld_hu, op_ld_w}) begin
                e.we = 1'b1;
            end
        end
        return e;
    endfunction

    task automatic check_result(pc_t pc, reg_addr_t dest, mem_op_t op,
                                logic [xlen-1:0] data, logic we);
        if (wb_pc !== pc || wb_dest !== dest || wb_data !== data || wb_we !== we) begin
            mismatches++;
            $display("mismatch at %0t: %s pc %h got %0d/%h/%b want %0d/%h/%b (dest/data/we)",
                     $time, op.name(), pc, wb_dest, wb_data, wb_we, dest, data, we);
        end
    endtask

    task automatic check_excp(pc_t pc, mem_op_t op, logic excp);
        if (wb_excp !== excp) begin
            mismatches++;
            $display("mismatch at %0t: %s pc %h got excp %b, want %b",
                     $time, op.name(), pc, wb_excp, excp);
        end
    endtask

    // retirement monitor samples at the falling edge
    always @(negedge clk) begin
        if (!reset && wb_valid && !retire_stall) begin
            if (exp_q.size() == 0) begin
                failures++;
                $display("at %0t an instruction with pc %h retired that should not retire",
                         $time, wb_pc);
            end else begin
                retired = exp_q.pop_front();
                check_result(retired.pc, retired.dest, retired.op, retired.data, retired.we);
                check_excp(retired.pc, retired.op, retired.excp);
            end
        end
    end

    task automatic drive_instr(pc_t pc, row_t r);
        in_valid  = 1'b1;
        in_pc     = pc;
        in_op     = r.op;
        in_dest   = r.dest;
        in_base   = r.base;
        in_offset = r.offset;
        in_data   = r.data;
    endtask

    task automatic issue_row(int i);
        int   waited;
        logic accepted;
        pc_t  pc;
        pc       = 32'h1000 + 4 * i;
        waited   = 0;
        accepted = 1'b0;
        drive_instr(pc, rows[i]);
        while (!accepted && waited < 100) begin
            @(negedge clk);
            accepted = in_allowin;
            @(posedge clk);
            waited++;
        end
        #1;
        in_valid = 1'b0;
        if (accepted) begin
            exp_q.push_back(predict_retirement(pc, rows[i]));
        end else begin
            failures++;
            $display("row %0d was never accepted, in_allowin stayed low", i);
        end
    endtask

    // single alu op with no stall takes three edges to the ports
    task automatic measure_latency();
        int   edges;
        row_t r;
        r = '{op_alu, 5'd31, 32'h0, 32'h0, 32'h5a5a_0f0f, 1'b0};
        drive_instr(32'h0f00, r);
        @(posedge clk);
        exp_q.push_back(predict_retirement(32'h0f00, r));
        #1;
        in_valid = 1'b0;
        edges = 1;
        @(negedge clk);
        while (!wb_valid && edges < 10) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end
        if (edges != 3) begin
            mismatches++;
            $display("mismatch at %0t: alu op reached the ports after %0d edges, want 3",
                     $time, edges);
        end
    endtask

    initial begin
        int waited;
        int gap;
        void'($urandom(32'hbf8eaabc));
        clk          = 1'b0;
        reset        = 1'b1;
        flush        = 1'b0;
        in_valid     = 1'b0;
        in_pc        = '0;
        in_op        = op_alu;
        in_dest      = '0;
        in_base      = '0;
        in_offset    = '0;
        in_data      = '0;
        retire_stall = 1'b0;
        stall_on     = 1'b0;
        mismatches   = 0;
        failures     = 0;
        n_rows       = 0;

        // merged stores before a word load
        add_row(op_st_w, 5'd0, 32'h100, 32'h0, 32'h1122_3344, 1'b0);
        add_row(op_st_b, 5'd0, 32'h100, 32'h1, 32'h0000_00ab, 1'b0);
        add_row(op_st_h, 5'd0, 32'h100, 32'h2, 32'h0000_cdef, 1'b0);
        add_row(op_ld_w, 5'd1, 32'h100, 32'h0, 32'h0, 1'b0);
        add_row(op_st_w, 5'd0, 32'h104, 32'h0, 32'h80f0_7f81, 1'b0);
        add_row(op_st_w, 5'd0, 32'h108, 32'h0, 32'hdead_beef, 1'b0);
        add_row(op_st_h, 5'd0, 32'h108, 32'h0, 32'h0000_1234, 1'b0);
        add_row(op_st_b, 5'd0, 32'h108, 32'h3, 32'h0000_005a, 1'b0);
        add_row(op_ld_w, 5'd2, 32'h108, 32'h0, 32'h0, 1'b0);
        for (int k = 0; k < 4; k++) begin
            add_row(op_ld_b, reg_addr_t'(3 + k), 32'h104, k, 32'h0, 1'b0);
            add_row(op_ld_bu, reg_addr_t'(7 + k), 32'h104, k, 32'h0, 1'b0);
        end
        add_row(op_ld_h, 5'd11, 32'h104, 32'h0, 32'h0, 1'b0);
        add_row(op_ld_h, 5'd11, 32'h104, 32'h2, 32'h0, 1'b0);
        add_row(op_ld_hu, 5'd11, 32'h104, 32'h0, 32'h0, 1'b0);
        add_row(op_ld_hu, 5'd11, 32'h104, 32'h2, 32'h0, 1'b0);
        // misaligned accesses leave memory unchanged
        add_row(op_ld_h, 5'd12, 32'h104, 32'h1, 32'h0, 1'b0);
        add_row(op_ld_w, 5'd13, 32'h104, 32'h2, 32'h0, 1'b0);
        add_row(op_st_h, 5'd0, 32'h104, 32'h3, 32'h0000_ffff, 1'b0);
        add_row(op_st_w, 5'd0, 32'h100, 32'h6, 32'hffff_ffff, 1'b0);
        add_row(op_ld_w, 5'd14, 32'h104, 32'h0, 32'h0, 1'b0);
        add_row(op_ld_w, 5'd15, 32'h100, 32'h0, 32'h0, 1'b0);
        add_row(op_alu, 5'd16, 32'h0, 32'h0, 32'h1234_5678, 1'b0);
        add_row(op_alu, 5'd17, 32'h0, 32'h0, 32'hcafe_f00d, 1'b0);
        add_row(op_ld_w, 5'd18, 32'h10c, 32'hffff_fffc, 32'h0, 1'b0);
        add_row(op_alu, 5'd0, 32'h0, 32'h0, 32'h0, 1'b1);
        add_row(op_alu, 5'd19, 32'h0, 32'h0, 32'h0bad_c0de, 1'b0);
        add_row(op_ld_bu, 5'd20, 32'h108, 32'h3, 32'h0, 1'b0);
        add_row(op_alu, 5'd21, 32'h0, 32'h0, 32'h0000_0001, 1'b0);
        add_row(op_alu, 5'd0, 32'h0, 32'h0, 32'h0, 1'b1);
        add_row(op_ld_h, 5'd22, 32'h108, 32'h0, 32'h0, 1'b0);
        add_row(op_ld_b, 5'd23, 32'h104, 32'h3, 32'h0, 1'b0);

        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        measure_latency();
        @(posedge clk);
        #1;
        stall_on = 1'b1;

        for (int i = 0; i < n_rows; i++) begin
            if (rows[i].flush) begin
                // the row before is still in execute here
                flush = 1'b1;
                exp_q.delete();
                @(posedge clk);
                #1;
                flush = 1'b0;
            end else begin
                gap = $urandom % 3;
                if (gap > 0) begin
                    repeat (gap) @(posedge clk);
                    #1;
                end
                issue_row(i);
            end
        end

        waited = 0;
        while (exp_q.size() > 0 && waited < 200) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() > 0) begin
            failures++;
            $display("timed out with %0d instructions still waiting to retire", exp_q.size());
        end
        repeat (5) @(posedge clk);

        $display("checks done: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
hdl/pipe_pkg.sv
hdl/dmem_pkg.sv
hdl/ex_stage.sv
hdl/data_sram.sv
hdl/mem_stage.sv
hdl/wb_stage.sv
hdl/mem_pipe_top.sv
testbench/tb_mem_pipe.sv

// File: run.sh
#!/bin/sh
# build and run the memory pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module tb_mem_pipe -Mdir obj_dir -o sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^TEST RESULT: PASS$"; then
    exit 0
fi
exit 1
